//--- rtl/kbd_cfg.svh
`ifndef KBD_CFG_SVH
`define KBD_CFG_SVH

// queue address width, 4 entries
// the read and write pointers carry one extra wrap bit
`define KBD_QUEUE_AW 2

// width of one stored queue word
`define KBD_QUEUE_DW 32

// clk cycles without a falling ps2 clock edge before a partial frame is dropped
`define KBD_FRAME_TIMEOUT 200

`endif

//--- rtl/kbd_pkg.sv
`include "kbd_cfg.svh"

package kbd_pkg;

  // raw ps2 scan code
  typedef logic [7:0] scan_code_t;

  // translated character, 0 when the key has none
  typedef logic [7:0] ascii_t;

  // bit 2 extended, bit 1 ctrl, bit 0 shift
  typedef logic [2:0] key_status_t;

  // {status[18:16], scan[15:8], ascii[7:0]}
  typedef logic [18:0] char_entry_t;

  // zero fill, make flag, then the entry
  typedef logic [`KBD_QUEUE_DW-1:0] queue_word_t;

  // position of a bit inside the 11-bit frame
  typedef logic [3:0] bit_idx_t;

  // prefix tracking in the scan decoder
  typedef enum logic [1:0] {
    DEC_IDLE,
    DEC_EXT,
    DEC_BRK,
    DEC_EXT_BRK
  } dec_state_t;

  // queue control
  typedef enum logic [1:0] {
    Q_IDLE,
    Q_PUSH,
    Q_POP
  } q_state_t;

endpackage

//--- rtl/ps2_edge_timer.sv
`timescale 1ns/1ps
`include "kbd_cfg.svh"

module ps2_edge_timer (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              ps2_clk_i,
  input  logic              ps2_data_i,
  output logic              sample_o,
  output logic              data_sync_o,
  output kbd_pkg::bit_idx_t bit_idx_o,
  output logic              frame_abort_o
);

  localparam int TMO_W = $clog2(`KBD_FRAME_TIMEOUT + 1);

  logic             clk_s1, clk_s2, clk_prev;
  logic             data_s1, data_s2;
  logic             fall;
  logic [TMO_W-1:0] idle_cnt;

  // falling edge seen on the synchronized ps2 clock
  assign fall = clk_prev & ~clk_s2;

  // two flop synchronizers, lines idle high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      clk_s1   <= 1'b1;
      clk_s2   <= 1'b1;
      clk_prev <= 1'b1;
      data_s1  <= 1'b1;
      data_s2  <= 1'b1;
    end else begin
      clk_s1   <= ps2_clk_i;
      clk_s2   <= clk_s1;
      clk_prev <= clk_s2;
      data_s1  <= ps2_data_i;
      data_s2  <= data_s1;
    end
  end

  // strobe and data bit are registered together
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sample_o    <= 1'b0;
      data_sync_o <= 1'b1;
    end else begin
      sample_o    <= fall;
      data_sync_o <= data_s2;
    end
  end

  // bit position and idle timer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_idx_o     <= '0;
      idle_cnt      <= '0;
      frame_abort_o <= 1'b0;
    end else begin
      frame_abort_o <= 1'b0;
      if (sample_o) begin
        idle_cnt  <= '0;
        bit_idx_o <= (bit_idx_o == 4'd10) ? 4'd0 : bit_idx_o + 4'd1;
      end else if (bit_idx_o != 4'd0) begin
        // stalled mid-frame, give up on it
        if (idle_cnt == TMO_W'(`KBD_FRAME_TIMEOUT - 1)) begin
          frame_abort_o <= 1'b1;
          bit_idx_o     <= '0;
          idle_cnt      <= '0;
        end else begin
          idle_cnt <= idle_cnt + 1'b1;
        end
      end else begin
        idle_cnt <= '0;
      end
    end
  end

  // frame position stays inside the 11-bit frame
  a_bit_idx_range : assert property (@(posedge clk) disable iff (!rst_n)
    bit_idx_o <= 4'd10);

endmodule

//--- rtl/ps2_frame_rx.sv
`timescale 1ns/1ps

module ps2_frame_rx (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                sample_i,
  input  logic                data_i,
  input  logic                frame_abort_i,
  input  kbd_pkg::bit_idx_t   bit_idx_i,
  output logic                code_valid_o,
  output kbd_pkg::scan_code_t code_o
);

  logic [10:0] shift_q;
  logic [10:0] frame;
  logic        last_bit;
  logic        frame_ok;

  // ps2 sends lsb first, so new bits enter at the top
  assign frame    = {data_i, shift_q[10:1]};
  assign last_bit = sample_i && (bit_idx_i == 4'd10);

  // start low, odd parity over data and parity bit, stop high
  assign frame_ok = !frame[0] && (^frame[9:1]) && frame[10];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shift_q      <= '0;
      code_valid_o <= 1'b0;
    end else begin
      code_valid_o <= last_bit && frame_ok;
      if (frame_abort_i) begin
        shift_q <= '0;
      end else if (sample_i) begin
        shift_q <= frame;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (last_bit) begin
      code_o <= frame[8:1];
    end
  end

  // frames are at least eleven samples apart
  a_valid_single : assert property (@(posedge clk) disable iff (!rst_n)
    code_valid_o |=> !code_valid_o);

endmodule

//--- rtl/scan_decoder.sv
`timescale 1ns/1ps

module scan_decoder (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 code_valid_i,
  input  kbd_pkg::scan_code_t  code_i,
  output logic                 write_o,
  output logic                 make_o,
  output kbd_pkg::char_entry_t entry_o
);

  kbd_pkg::dec_state_t  state_q, state_d;
  logic                 shift_q, ctrl_q;
  logic                 key_event;
  logic                 is_make, is_ext;
  logic                 is_shift, is_ctrl;
  kbd_pkg::ascii_t      raw_ascii, ascii;
  kbd_pkg::key_status_t status;

  // lower case translation, 0 for anything without a character
  function automatic kbd_pkg::ascii_t to_ascii(input kbd_pkg::scan_code_t code);
    case (code)
      8'h1C: to_ascii = 8'h61;
      8'h32: to_ascii = 8'h62;
      8'h21: to_ascii = 8'h63;
      8'h23: to_ascii = 8'h64;
      8'h24: to_ascii = 8'h65;
      8'h2B: to_ascii = 8'h66;
      8'h34: to_ascii = 8'h67;
      8'h33: to_ascii = 8'h68;
      8'h43: to_ascii = 8'h69;
      8'h3B: to_ascii = 8'h6A;
      8'h42: to_ascii = 8'h6B;
      8'h4B: to_ascii = 8'h6C;
      8'h3A: to_ascii = 8'h6D;
      8'h31: to_ascii = 8'h6E;
      8'h44: to_ascii = 8'h6F;
      8'h4D: to_ascii = 8'h70;
      8'h15: to_ascii = 8'h71;
      8'h2D: to_ascii = 8'h72;
      8'h1B: to_ascii = 8'h73;
      8'h2C: to_ascii = 8'h74;
      8'h3C: to_ascii = 8'h75;
      8'h2A: to_ascii = 8'h76;
      8'h1D: to_ascii = 8'h77;
      8'h22: to_ascii = 8'h78;
      8'h35: to_ascii = 8'h79;
      8'h1A: to_ascii = 8'h7A;
      8'h45: to_ascii = 8'h30;
      8'h16: to_ascii = 8'h31;
      8'h1E: to_ascii = 8'h32;
      8'h26: to_ascii = 8'h33;
      8'h25: to_ascii = 8'h34;
      8'h2E: to_ascii = 8'h35;
      8'h36: to_ascii = 8'h36;
      8'h3D: to_ascii = 8'h37;
      8'h3E: to_ascii = 8'h38;
      8'h46: to_ascii = 8'h39;
      8'h29: to_ascii = 8'h20;
      8'h5A: to_ascii = 8'h0D;
      default: to_ascii = 8'h00;
    endcase
  endfunction

  assign is_make  = (state_q == kbd_pkg::DEC_IDLE) || (state_q == kbd_pkg::DEC_EXT);
  assign is_ext   = (state_q == kbd_pkg::DEC_EXT) || (state_q == kbd_pkg::DEC_EXT_BRK);
  assign is_shift = (code_i == 8'h12) || (code_i == 8'h59);
  assign is_ctrl  = (code_i == 8'h14);

  assign raw_ascii = to_ascii(code_i);
  // letters go upper case while shift is held
  assign ascii  = (shift_q && raw_ascii >= 8'h61 && raw_ascii <= 8'h7A) ?
                  raw_ascii - 8'h20 : raw_ascii;
  assign status = {is_ext, ctrl_q, shift_q};

  // prefixes only move the state, every other code ends a key event
  always_comb begin
    state_d   = kbd_pkg::DEC_IDLE;
    key_event = 1'b0;
    case (code_i)
      8'hE0: state_d = kbd_pkg::DEC_EXT;
      8'hF0: state_d = is_ext ? kbd_pkg::DEC_EXT_BRK : kbd_pkg::DEC_BRK;
      default: key_event = 1'b1;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= kbd_pkg::DEC_IDLE;
      shift_q <= 1'b0;
      ctrl_q  <= 1'b0;
      write_o <= 1'b0;
    end else begin
      write_o <= 1'b0;
      if (code_valid_i) begin
        state_q <= state_d;
        if (key_event) begin
          write_o <= 1'b1;
          if (is_shift) shift_q <= is_make;
          if (is_ctrl) ctrl_q <= is_make;
        end
      end
    end
  end

  // modifiers produce the all-ones entry that the queue discards
  always_ff @(posedge clk) begin
    if (code_valid_i && key_event) begin
      make_o  <= is_make;
      entry_o <= (is_shift || is_ctrl) ? '1 : {status, code_i, ascii};
    end
  end

endmodule

//--- rtl/char_queue_mem.sv
`timescale 1ns/1ps
`include "kbd_cfg.svh"

module char_queue_mem (
  input  logic                     clk,
  input  logic                     we_i,
  input  logic [`KBD_QUEUE_AW-1:0] raddr_i,
  input  logic [`KBD_QUEUE_AW-1:0] waddr_i,
  input  kbd_pkg::queue_word_t     wdata_i,
  output kbd_pkg::queue_word_t     rdata_o
);

  kbd_pkg::queue_word_t mem_q [0:(1 << `KBD_QUEUE_AW)-1];

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // read port is combinational
  assign rdata_o = mem_q[raddr_i];

endmodule

//--- rtl/char_queue.sv
`timescale 1ns/1ps
`include "kbd_cfg.svh"

module char_queue (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 write_i,
  input  logic                 read_i,
  input  logic                 make_i,
  input  kbd_pkg::char_entry_t entry_i,
  output kbd_pkg::queue_word_t entry_o,
  output logic                 char_queue_empty_o,
  output logic                 char_queue_full_o
);

  localparam int AW    = `KBD_QUEUE_AW;
  localparam int DEPTH = 1 << AW;

  logic [AW:0]          read_ptr, write_ptr;
  logic [AW:0]          occupancy;
  logic                 read_ptr_inc, write_ptr_inc;
  logic                 mem_we;
  logic                 set_output;
  logic                 attempt_read_empty;
  kbd_pkg::queue_word_t queue_data;
  kbd_pkg::queue_word_t sustain_q;
  kbd_pkg::q_state_t    state_q, state_d;

  // same address, wrap bits tell full from empty
  assign char_queue_full_o  = (read_ptr[AW-1:0] == write_ptr[AW-1:0]) &&
                              (read_ptr[AW] != write_ptr[AW]);
  assign char_queue_empty_o = (read_ptr == write_ptr);
  assign occupancy          = write_ptr - read_ptr;

  char_queue_mem u_mem (
    .clk     (clk),
    .we_i    (mem_we),
    .raddr_i (read_ptr[AW-1:0]),
    .waddr_i (write_ptr[AW-1:0]),
    .wdata_i ({{(`KBD_QUEUE_DW-20){1'b0}}, make_i, entry_i}),
    .rdata_o (queue_data)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= kbd_pkg::Q_IDLE;
      read_ptr  <= '0;
      write_ptr <= '0;
      sustain_q <= '0;
    end else begin
      state_q <= state_d;
      if (read_ptr_inc) read_ptr <= read_ptr + 1'b1;
      if (write_ptr_inc) write_ptr <= write_ptr + 1'b1;
      // popped word stays visible until the next pop
      if (set_output) sustain_q <= queue_data;
    end
  end

  assign entry_o = attempt_read_empty ? '0 : sustain_q;

  always_comb begin
    state_d            = kbd_pkg::Q_IDLE;
    mem_we             = 1'b0;
    read_ptr_inc       = 1'b0;
    write_ptr_inc      = 1'b0;
    set_output         = 1'b0;
    attempt_read_empty = 1'b0;
    case (state_q)
      kbd_pkg::Q_PUSH: begin
        // store now, stay until the strobe is gone
        mem_we        = 1'b1;
        write_ptr_inc = 1'b1;
        state_d       = write_i ? kbd_pkg::Q_PUSH : kbd_pkg::Q_IDLE;
      end
      kbd_pkg::Q_POP: begin
        // one read level pops a single word
        state_d = read_i ? kbd_pkg::Q_POP : kbd_pkg::Q_IDLE;
      end
      default: begin
        if (write_i) begin
          // full queue and modifier entries are dropped
          if (!char_queue_full_o && !(&entry_i)) state_d = kbd_pkg::Q_PUSH;
        end else if (read_i) begin
          if (!char_queue_empty_o) begin
            read_ptr_inc = 1'b1;
            set_output   = 1'b1;
            state_d      = kbd_pkg::Q_POP;
          end else begin
            attempt_read_empty = 1'b1;
          end
        end
      end
    endcase
  end

  // write pointer never laps the read pointer and vice versa
  a_occupancy : assert property (@(posedge clk) disable iff (!rst_n)
    occupancy <= (AW+1)'(DEPTH));

endmodule

//--- rtl/kbd_ctrl_top.sv
`timescale 1ns/1ps

module kbd_ctrl_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 ps2_clk_i,
  input  logic                 ps2_data_i,
  input  logic                 read_i,
  output kbd_pkg::queue_word_t entry_o,
  output logic                 char_queue_empty_o,
  output logic                 char_queue_full_o
);

  logic                 sample;
  logic                 data_sync;
  logic                 frame_abort;
  kbd_pkg::bit_idx_t    bit_idx;
  logic                 code_valid;
  kbd_pkg::scan_code_t  code;
  logic                 dec_write;
  logic                 dec_make;
  kbd_pkg::char_entry_t dec_entry;

  ps2_edge_timer u_edge_timer (
    .clk           (clk),
    .rst_n         (rst_n),
    .ps2_clk_i     (ps2_clk_i),
    .ps2_data_i    (ps2_data_i),
    .sample_o      (sample),
    .data_sync_o   (data_sync),
    .bit_idx_o     (bit_idx),
    .frame_abort_o (frame_abort)
  );

  ps2_frame_rx u_frame_rx (
    .clk           (clk),
    .rst_n         (rst_n),
    .sample_i      (sample),
    .data_i        (data_sync),
    .frame_abort_i (frame_abort),
    .bit_idx_i     (bit_idx),
    .code_valid_o  (code_valid),
    .code_o        (code)
  );

  scan_decoder u_decoder (
    .clk          (clk),
    .rst_n        (rst_n),
    .code_valid_i (code_valid),
    .code_i       (code),
    .write_o      (dec_write),
    .make_o       (dec_make),
    .entry_o      (dec_entry)
  );

  char_queue u_queue (
    .clk                (clk),
    .rst_n              (rst_n),
    .write_i            (dec_write),
    .read_i             (read_i),
    .make_i             (dec_make),
    .entry_i            (dec_entry),
    .entry_o            (entry_o),
    .char_queue_empty_o (char_queue_empty_o),
    .char_queue_full_o  (char_queue_full_o)
  );

endmodule

//--- verification/kbd_ctrl_tb.sv
`timescale 1ns/1ps
`include "kbd_cfg.svh"

module kbd_ctrl_tb;

  localparam int MAX_CYCLES = 40000;
  localparam int HALF_BIT   = 20;

  // scan codes of the letters a to z in alphabet order
  localparam logic [7:0] LETTER_CODES [0:25] = '{
    8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43, 8'h3B,
    8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C,
    8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A
  };

  // scan codes of the digits 0 to 9
  localparam logic [7:0] DIGIT_CODES [0:9] = '{
    8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46
  };

  logic        clk = 1'b0;
  logic        rst_n;
  logic        ps2_clk;
  logic        ps2_data;
  logic        read_i;
  logic [31:0] entry_o;
  logic        char_queue_empty_o;
  logic        char_queue_full_o;

  integer      seed = 32'he062;
  int          cycle_count = 0;
  int          err_count = 0;
  logic [31:0] word;

  kbd_ctrl_top UUT (
    .clk                (clk),
    .rst_n              (rst_n),
    .ps2_clk_i          (ps2_clk),
    .ps2_data_i         (ps2_data),
    .read_i             (read_i),
    .entry_o            (entry_o),
    .char_queue_empty_o (char_queue_empty_o),
    .char_queue_full_o  (char_queue_full_o)
  );

  always #4 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("** FAIL **");
      $fatal(1, "cycle limit reached");
    end
  end

  task automatic check_eq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    if (expected !== actual) begin
      err_count++;
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      $display("** FAIL **");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // expected queue word from the ps2 scan code set 2 layout
  function automatic logic [31:0] expected_word(input logic make, input logic [2:0] status,
                                                input logic [7:0] scan);
    logic [7:0] ascii;
    int         i;
    ascii = 8'h00;
    for (i = 0; i < 26; i++) begin
      if (LETTER_CODES[i] == scan) begin
        ascii = (status[0] ? 8'h41 : 8'h61) + 8'(i);
      end
    end
    for (i = 0; i < 10; i++) begin
      if (DIGIT_CODES[i] == scan) begin
        ascii = 8'h30 + 8'(i);
      end
    end
    if (scan == 8'h29) ascii = 8'h20;
    if (scan == 8'h5A) ascii = 8'h0D;
    return {12'h000, make, status, scan, ascii};
  endfunction

  // data changes while the ps2 clock is high and is sampled on the fall
  task automatic send_bits(input logic [10:0] frame, input int count);
    int i;
    for (i = 0; i < count; i++) begin
      ps2_data <= frame[i];
      repeat (HALF_BIT) @(posedge clk);
      ps2_clk <= 1'b0;
      repeat (HALF_BIT) @(posedge clk);
      ps2_clk <= 1'b1;
    end
    ps2_data <= 1'b1;
  endtask

  task automatic idle_gap();
    int gap;
    gap = 10 + ($unsigned($random(seed)) % 30);
    repeat (gap) @(posedge clk);
  endtask

  task automatic send_byte(input logic [7:0] code, input logic bad_parity);
    logic parity;
    // odd parity over data and parity bit
    parity = ~(^code) ^ bad_parity;
    send_bits({1'b1, parity, code, 1'b0}, 11);
    idle_gap();
  endtask

  // one read level sampled mid cycle after the pop edge
  task automatic read_entry(output logic [31:0] value);
    read_i <= 1'b1;
    @(posedge clk);
    @(negedge clk);
    value = entry_o;
    @(posedge clk);
    read_i <= 1'b0;
    @(posedge clk);
  endtask

  task automatic make_break_letter();
    send_byte(8'h1C, 1'b0);
    send_byte(8'hF0, 1'b0);
    send_byte(8'h1C, 1'b0);
    read_entry(word);
    check_eq("make_break make", expected_word(1'b1, 3'b000, 8'h1C), word);
    read_entry(word);
    check_eq("make_break break", expected_word(1'b0, 3'b000, 8'h1C), word);
    check_eq("make_break empty", 32'd1, 32'(char_queue_empty_o));
  endtask

  task automatic shift_and_drop();
    send_byte(8'h12, 1'b0);
    send_byte(8'h1C, 1'b0);
    read_entry(word);
    check_eq("shift upper", expected_word(1'b1, 3'b001, 8'h1C), word);
    // the dropped shift entry leaves a single word
    check_eq("shift one word", 32'd1, 32'(char_queue_empty_o));
    send_byte(8'hF0, 1'b0);
    send_byte(8'h12, 1'b0);
    check_eq("shift release dropped", 32'd1, 32'(char_queue_empty_o));
    send_byte(8'h1C, 1'b0);
    read_entry(word);
    check_eq("shift lower", expected_word(1'b1, 3'b000, 8'h1C), word);
  endtask

  task automatic extended_key();
    send_byte(8'hE0, 1'b0);
    send_byte(8'h75, 1'b0);
    read_entry(word);
    check_eq("extended", expected_word(1'b1, 3'b100, 8'h75), word);
  endtask

  task automatic full_and_empty();
    int i;
    for (i = 1; i <= 5; i++) begin
      send_byte(DIGIT_CODES[i], 1'b0);
    end
    check_eq("full flag", 32'd1, 32'(char_queue_full_o));
    // the fifth digit is lost and the first four return in order
    for (i = 1; i <= 4; i++) begin
      read_entry(word);
      check_eq("full order", expected_word(1'b1, 3'b000, DIGIT_CODES[i]), word);
    end
    check_eq("drained empty", 32'd1, 32'(char_queue_empty_o));
    check_eq("drained not full", 32'd0, 32'(char_queue_full_o));
    read_entry(word);
    check_eq("read on empty", 32'd0, word);
    // last popped word shows again once read_i is low
    check_eq("sustained word", expected_word(1'b1, 3'b000, DIGIT_CODES[4]), entry_o);
  endtask

  task automatic frame_errors();
    send_byte(8'h1C, 1'b1);
    check_eq("bad parity", 32'd1, 32'(char_queue_empty_o));
    // half a frame followed by enough silence for the abort
    send_bits({1'b1, 1'b0, 8'h1C, 1'b0}, 5);
    repeat (`KBD_FRAME_TIMEOUT + 50) @(posedge clk);
    // decodes only if the abort realigned the bit count
    send_byte(8'h24, 1'b0);
    read_entry(word);
    check_eq("recovery", expected_word(1'b1, 3'b000, 8'h24), word);
  endtask

  initial begin
    rst_n    = 1'b0;
    ps2_clk  = 1'b1;
    ps2_data = 1'b1;
    read_i   = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    repeat (3) @(posedge clk);

    check_eq("reset empty", 32'd1, 32'(char_queue_empty_o));
    check_eq("reset full", 32'd0, 32'(char_queue_full_o));
    check_eq("reset entry", 32'd0, entry_o);

    make_break_letter();
    shift_and_drop();
    extended_key();
    full_and_empty();
    frame_errors();

    repeat (5) @(posedge clk);
    if (err_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+rtl
rtl/kbd_pkg.sv
rtl/ps2_edge_timer.sv
rtl/ps2_frame_rx.sv
rtl/scan_decoder.sv
rtl/char_queue_mem.sv
rtl/char_queue.sv
rtl/kbd_ctrl_top.sv
verification/kbd_ctrl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the keyboard controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f tb.f --top-module kbd_ctrl_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vkbd_ctrl_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see $LOG"
  exit 1
fi
